// File: verilog/elem_pkg.sv
//////////////////////////////////////////////////////////////////////
// Element result collector package.
// Shared widths, enums and packed structs of the collector.
//////////////////////////////////////////////////////////////////////

package elem_pkg;

        // Instruction id width.
        localparam int unsigned ID_W = 3;

        // Vector register address width.
        localparam int unsigned VADDR_W = 5;

        // Width of one element result, right-aligned.
        localparam int unsigned ELEM_W = 32;

        // Register index within a group of up to 8 registers.
        localparam int unsigned MUL_IDX_W = 3;

        typedef enum logic [1:0] {
                EEW_8  = 2'd0,
                EEW_16 = 2'd1,
                EEW_32 = 2'd2
        } eew_e;

        typedef enum logic [1:0] {
                EMUL_1 = 2'd0,
                EMUL_2 = 2'd1,
                EMUL_4 = 2'd2,
                EMUL_8 = 2'd3
        } emul_e;

        typedef enum logic {
                ST_COLLECT = 1'b0,
                ST_FLUSH   = 1'b1
        } collect_state_e;

        // Instruction fields held for the group padding.
        typedef struct packed {
                logic [ID_W-1:0]    id;
                eew_e               eew;
                emul_e              emul;
                logic [VADDR_W-1:0] vaddr;
        } instr_ctrl_t;

        // One element result as delivered by the source.
        typedef struct packed {
                instr_ctrl_t        ctrl;
                logic               first;
                logic               last;
                logic               requires_flush;
                logic [ELEM_W-1:0]  data;
                logic               mask;
        } elem_in_t;

        // Write port control without the data.
        typedef struct packed {
                logic [ID_W-1:0]    id;
                logic [VADDR_W-1:0] vaddr;
                logic               instr_done;
        } wr_ctrl_t;

endpackage

// File: verilog/elem_flush_fsm.sv
//////////////////////////////////////////////////////////////////////
// Collect and flush state machine.
// Tracks group padding after a flushing instruction and flags its end.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module elem_flush_fsm (
        input  logic                   clk_i,
        input  logic                   async_rst_ni,

        input  logic                   elem_valid_i,
        input  elem_pkg::elem_in_t     elem_i,
        input  logic                   group_full_i,

        output logic                   flushing_o,
        output elem_pkg::instr_ctrl_t  flush_ctrl_o,
        output logic                   done_o
);

        elem_pkg::collect_state_e state_q;
        elem_pkg::collect_state_e state_d;
        elem_pkg::instr_ctrl_t    flush_ctrl_q;

        logic last_strobe;
        logic start_flush;
        logic end_flush;

        //////////////////////////////////////////////////////////////////////
        // Next state.
        //////////////////////////////////////////////////////////////////////

        // Last element of an instruction seen while collecting.
        assign last_strobe = (state_q == elem_pkg::ST_COLLECT) & elem_valid_i & elem_i.last;

        // Padding is only needed if the group is still open.
        assign start_flush = last_strobe & elem_i.requires_flush & ~group_full_i;

        // The padding element of this cycle closes the group.
        assign end_flush = (state_q == elem_pkg::ST_FLUSH) & group_full_i;

        always_comb begin
                state_d = state_q;
                unique case (state_q)
                        elem_pkg::ST_COLLECT: begin
                                if (start_flush) begin
                                        state_d = elem_pkg::ST_FLUSH;
                                end
                        end
                        elem_pkg::ST_FLUSH: begin
                                if (end_flush) begin
                                        state_d = elem_pkg::ST_COLLECT;
                                end
                        end
                        default: begin
                                state_d = elem_pkg::ST_COLLECT;
                        end
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // Registers.
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        state_q <= elem_pkg::ST_COLLECT;
                end else begin
                        state_q <= state_d;
                end
        end

        // Fields of the flushing instruction, used for the padding.
        always_ff @(posedge clk_i) begin
                if (start_flush) begin
                        flush_ctrl_q <= elem_i.ctrl;
                end
        end

        assign flushing_o   = (state_q == elem_pkg::ST_FLUSH);
        assign flush_ctrl_o = flush_ctrl_q;

        // This cycle completes the instruction.
        assign done_o = (last_strobe & ~start_flush) | end_flush;

endmodule

// File: verilog/elem_byte_counter.sv
//////////////////////////////////////////////////////////////////////
// Byte position counter across a vector register group.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module elem_byte_counter #(
        parameter int unsigned VREG_W = 128
) (
        input  logic                            clk_i,
        input  logic                            async_rst_ni,

        input  logic                            step_i,
        input  logic                            first_i,
        input  elem_pkg::instr_ctrl_t           ctrl_i,

        output logic                            reg_full_o,
        output logic                            group_full_o,
        output logic [elem_pkg::MUL_IDX_W-1:0]  mul_idx_o
);

        // Byte offset bits within one register, then the register index.
        localparam int unsigned BYTE_W = $clog2(VREG_W / 8);
        localparam int unsigned CNT_W  = BYTE_W + elem_pkg::MUL_IDX_W;

        logic [CNT_W-1:0]               cnt_q;
        logic [CNT_W-1:0]               cnt_d;
        logic [2:0]                     elem_bytes;
        logic [elem_pkg::MUL_IDX_W-1:0] grp_last;

        always_comb begin
                unique case (ctrl_i.eew)
                        elem_pkg::EEW_16: elem_bytes = 3'd2;
                        elem_pkg::EEW_32: elem_bytes = 3'd4;
                        default:          elem_bytes = 3'd1;
                endcase
        end

        // Index of the last register in the group.
        always_comb begin
                unique case (ctrl_i.emul)
                        elem_pkg::EMUL_2: grp_last = 3'd1;
                        elem_pkg::EMUL_4: grp_last = 3'd3;
                        elem_pkg::EMUL_8: grp_last = 3'd7;
                        default:          grp_last = 3'd0;
                endcase
        end

        // The count points at the last byte written so far.
        always_comb begin
                cnt_d = cnt_q;
                if (step_i) begin
                        if (first_i) begin
                                cnt_d = CNT_W'(elem_bytes - 3'd1);
                        end else begin
                                cnt_d = cnt_q + CNT_W'(elem_bytes);
                        end
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        cnt_q <= '0;
                end else begin
                        cnt_q <= cnt_d;
                end
        end

        assign mul_idx_o    = cnt_d[CNT_W-1:BYTE_W] & grp_last;
        assign reg_full_o   = &cnt_d[BYTE_W-1:0];
        assign group_full_o = reg_full_o & (mul_idx_o == grp_last);

endmodule

// File: verilog/elem_vreg_packer.sv
//////////////////////////////////////////////////////////////////////
// Vector register packer.
// Shifts element bytes and byte enables into one register word.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module elem_vreg_packer #(
        parameter int unsigned VREG_W = 128
) (
        input  logic                          clk_i,
        input  logic                          async_rst_ni,

        input  logic                          shift_i,
        input  elem_pkg::eew_e                eew_i,
        input  logic [elem_pkg::ELEM_W-1:0]   data_i,
        input  logic                          en_i,

        output logic [VREG_W-1:0]             data_o,
        output logic [VREG_W/8-1:0]           ben_o
);

        localparam int unsigned BEN_W = VREG_W / 8;

        logic [VREG_W-1:0] data_q;
        logic [VREG_W-1:0] data_d;
        logic [BEN_W-1:0]  ben_q;
        logic [BEN_W-1:0]  ben_d;

        // New element enters at the top, older bytes move down.
        always_comb begin
                data_d = data_q;
                ben_d  = ben_q;
                if (shift_i) begin
                        unique case (eew_i)
                                elem_pkg::EEW_16: begin
                                        data_d = {data_i[15:0], data_q[VREG_W-1:16]};
                                        ben_d  = {{2{en_i}}, ben_q[BEN_W-1:2]};
                                end
                                elem_pkg::EEW_32: begin
                                        data_d = {data_i[31:0], data_q[VREG_W-1:32]};
                                        ben_d  = {{4{en_i}}, ben_q[BEN_W-1:4]};
                                end
                                default: begin
                                        data_d = {data_i[7:0], data_q[VREG_W-1:8]};
                                        ben_d  = {en_i, ben_q[BEN_W-1:1]};
                                end
                        endcase
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        ben_q <= '0;
                end else begin
                        ben_q <= ben_d;
                end
        end

        always_ff @(posedge clk_i) begin
                data_q <= data_d;
        end

        // Shifted value of this cycle, so a completing element is included.
        assign data_o = data_d;
        assign ben_o  = ben_d;

endmodule

// File: verilog/elem_result_collector.sv
//////////////////////////////////////////////////////////////////////
// Element result collector.
// Packs element results into vector register writes with group padding.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module elem_result_collector #(
        parameter int unsigned VREG_W = 128
) (
        input  logic                  clk_i,
        input  logic                  async_rst_ni,

        input  logic                  elem_valid_i,
        input  elem_pkg::elem_in_t    elem_i,

        output logic                  wr_valid_o,
        output elem_pkg::wr_ctrl_t    wr_ctrl_o,
        output logic [VREG_W-1:0]     wr_data_o,
        output logic [VREG_W/8-1:0]   wr_ben_o,

        output logic                  done_o,
        output logic                  busy_o
);

        logic                             flushing;
        elem_pkg::instr_ctrl_t            flush_ctrl;
        elem_pkg::instr_ctrl_t            eff_ctrl;
        logic                             fsm_done;
        logic                             step;
        logic                             reg_full;
        logic                             group_full;
        logic [elem_pkg::MUL_IDX_W-1:0]   mul_idx;
        logic [elem_pkg::ELEM_W-1:0]      pack_data_in;
        logic                             pack_en;
        logic [VREG_W-1:0]                pack_data;
        logic [VREG_W/8-1:0]              pack_ben;
        logic                             wr_en;

        logic                             wr_valid_q;
        logic                             wr_done_q;
        logic [elem_pkg::ID_W-1:0]        wr_id_q;
        logic [elem_pkg::VADDR_W-1:0]     wr_vaddr_q;
        logic [VREG_W-1:0]                wr_data_q;
        logic [VREG_W/8-1:0]              wr_ben_q;

        // Padding uses the held fields, zero data and no enables.
        assign eff_ctrl     = flushing ? flush_ctrl : elem_i.ctrl;
        assign step         = elem_valid_i | flushing;
        assign pack_data_in = flushing ? '0 : elem_i.data;
        assign pack_en      = ~flushing & elem_i.mask;

        elem_flush_fsm u_fsm (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .elem_valid_i ( elem_valid_i ),
                .elem_i       ( elem_i       ),
                .group_full_i ( group_full   ),
                .flushing_o   ( flushing     ),
                .flush_ctrl_o ( flush_ctrl   ),
                .done_o       ( fsm_done     )
        );

        elem_byte_counter #(
                .VREG_W       ( VREG_W                    )
        ) u_cnt (
                .clk_i        ( clk_i                     ),
                .async_rst_ni ( async_rst_ni              ),
                .step_i       ( step                      ),
                .first_i      ( elem_i.first & ~flushing  ),
                .ctrl_i       ( eff_ctrl                  ),
                .reg_full_o   ( reg_full                  ),
                .group_full_o ( group_full                ),
                .mul_idx_o    ( mul_idx                   )
        );

        elem_vreg_packer #(
                .VREG_W       ( VREG_W       )
        ) u_pack (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .shift_i      ( step         ),
                .eew_i        ( eff_ctrl.eew ),
                .data_i       ( pack_data_in ),
                .en_i         ( pack_en      ),
                .data_o       ( pack_data    ),
                .ben_o        ( pack_ben     )
        );

        //////////////////////////////////////////////////////////////////////
        // Write port register.
        //////////////////////////////////////////////////////////////////////

        assign wr_en = step & reg_full;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        wr_valid_q <= 1'b0;
                        wr_done_q  <= 1'b0;
                end else begin
                        wr_valid_q <= wr_en;
                        wr_done_q  <= fsm_done;
                end
        end

        always_ff @(posedge clk_i) begin
                if (wr_en) begin
                        wr_id_q    <= eff_ctrl.id;
                        wr_vaddr_q <= eff_ctrl.vaddr |
                                      {{(elem_pkg::VADDR_W - elem_pkg::MUL_IDX_W){1'b0}}, mul_idx};
                        wr_data_q  <= pack_data;
                        wr_ben_q   <= pack_ben;
                end
        end

        assign wr_valid_o           = wr_valid_q;
        assign wr_ctrl_o.id         = wr_id_q;
        assign wr_ctrl_o.vaddr      = wr_vaddr_q;
        assign wr_ctrl_o.instr_done = wr_done_q;
        assign wr_data_o            = wr_data_q;
        assign wr_ben_o             = wr_ben_q;

        assign done_o = wr_done_q;
        assign busy_o = flushing;

endmodule

// File: test/elem_result_collector_assert.sv
//////////////////////////////////////////////////////////////////////
// Protocol assertions for the element result collector.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module elem_result_collector_assert (
        input logic clk_i,
        input logic async_rst_ni,
        input logic elem_valid_i,
        input logic wr_valid_i,
        input logic done_i,
        input logic busy_i
);

        // The source holds off while the group is padded.
        no_strobe_while_busy: assert property (
                @(posedge clk_i) disable iff (!async_rst_ni) busy_i |-> !elem_valid_i
        ) else $error("elem_valid_i strobed while busy_o is high");

        done_with_write: assert property (
                @(posedge clk_i) disable iff (!async_rst_ni) done_i |-> wr_valid_i
        ) else $error("done_o raised without wr_valid_o");

        idle_after_done: assert property (
                @(posedge clk_i) disable iff (!async_rst_ni) done_i |=> !busy_i
        ) else $error("busy_o high in the cycle after done_o");

endmodule

bind elem_result_collector elem_result_collector_assert u_assert (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .elem_valid_i ( elem_valid_i ),
        .wr_valid_i   ( wr_valid_o   ),
        .done_i       ( done_o       ),
        .busy_i       ( busy_o       )
);

// File: test/tb_elem_result_collector.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the element result collector.
// Table-driven instructions, LFSR element data and a packing model.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_elem_result_collector;

        localparam int unsigned VREG_W = 128;
        localparam int unsigned BEN_W  = VREG_W / 8;
        localparam int N_ROWS     = 9;
        localparam int WAIT_LIMIT = 300;

        // One instruction of the stimulus table.
        typedef struct packed {
                logic [elem_pkg::ID_W-1:0]    id;
                elem_pkg::eew_e               eew;
                elem_pkg::emul_e              emul;
                logic [elem_pkg::VADDR_W-1:0] vaddr;
                logic                         flush;
                int                           n_elem;
                logic [31:0]                  mask_pat;
                int                           n_writes;
        } row_t;

        // One expected register write.
        typedef struct packed {
                int                 row;
                int                 due;
                elem_pkg::wr_ctrl_t ctrl;
                logic [VREG_W-1:0]  data;
                logic [BEN_W-1:0]   ben;
        } exp_t;

        logic               clk_i;
        logic               async_rst_ni;
        logic               elem_valid_i;
        elem_pkg::elem_in_t elem_i;
        logic               wr_valid_o;
        elem_pkg::wr_ctrl_t wr_ctrl_o;
        logic [VREG_W-1:0]  wr_data_o;
        logic [BEN_W-1:0]   wr_ben_o;
        logic               done_o;
        logic               busy_o;

        row_t              rows [N_ROWS];
        int                seen [N_ROWS];
        exp_t              exp_q [$];
        logic [31:0]       lfsr_q = 32'he5e6_1810;
        logic [VREG_W-1:0] ref_data;
        logic [BEN_W-1:0]  ref_ben;
        int                ref_pos;
        int                ref_reg;
        int                cyc;
        int                n_checks;
        int                value_errs;
        int                proto_errs;
        logic              timed_out;

        elem_result_collector #(
                .VREG_W       ( VREG_W       )
        ) dut0 (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .elem_valid_i ( elem_valid_i ),
                .elem_i       ( elem_i       ),
                .wr_valid_o   ( wr_valid_o   ),
                .wr_ctrl_o    ( wr_ctrl_o    ),
                .wr_data_o    ( wr_data_o    ),
                .wr_ben_o     ( wr_ben_o     ),
                .done_o       ( done_o       ),
                .busy_o       ( busy_o       )
        );

        always #50 clk_i = ~clk_i;

        always @(posedge clk_i) cyc <= cyc + 1;

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic take_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_q = lfsr_next(lfsr_q);
                        v = {v[30:0], lfsr_q[0]};
                end
        endtask

        function automatic int eew_bytes(input elem_pkg::eew_e eew);
                case (eew)
                        elem_pkg::EEW_16: return 2;
                        elem_pkg::EEW_32: return 4;
                        default:          return 1;
                endcase
        endfunction

        function automatic int emul_regs(input elem_pkg::emul_e emul);
                case (emul)
                        elem_pkg::EMUL_2: return 2;
                        elem_pkg::EMUL_4: return 4;
                        elem_pkg::EMUL_8: return 8;
                        default:          return 1;
                endcase
        endfunction

        //////////////////////////////////////////////////////////////////////
        // Compare tasks.
        //////////////////////////////////////////////////////////////////////

        task automatic check_ctrl(input elem_pkg::wr_ctrl_t got, input elem_pkg::wr_ctrl_t want);
                n_checks++;
                if (got !== want) begin
                        $display("[ERROR] wr_ctrl_o: got 0x%h, expected 0x%h", got, want);
                        value_errs++;
                end
        endtask

        task automatic check_data(input logic [VREG_W-1:0] got, input logic [VREG_W-1:0] want);
                n_checks++;
                if (got !== want) begin
                        $display("[ERROR] wr_data_o: got 0x%h, expected 0x%h", got, want);
                        value_errs++;
                end
        endtask

        task automatic check_ben(input logic [BEN_W-1:0] got, input logic [BEN_W-1:0] want);
                n_checks++;
                if (got !== want) begin
                        $display("[ERROR] wr_ben_o: got 0x%h, expected 0x%h", got, want);
                        value_errs++;
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic want);
                n_checks++;
                if (got !== want) begin
                        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
                        value_errs++;
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Reference model and driver.
        //////////////////////////////////////////////////////////////////////

        // Bytes fill from byte 0 up; a full register becomes one expected write.
        task automatic model_element(input int r, input int nbytes, input int n_regs,
                        input logic [31:0] data, input logic en, input logic ends_instr,
                        input int due);
                exp_t e;
                for (int b = 0; b < nbytes; b++) begin
                        ref_data[ref_pos*8 +: 8] = data[b*8 +: 8];
                        ref_ben[ref_pos]         = en;
                        ref_pos++;
                end
                if (ref_pos == BEN_W) begin
                        e.row             = r;
                        e.due             = due;
                        e.ctrl.id         = rows[r].id;
                        e.ctrl.vaddr      = rows[r].vaddr | 5'(ref_reg);
                        e.ctrl.instr_done = ends_instr & (ref_reg == n_regs - 1);
                        e.data            = ref_data;
                        e.ben             = ref_ben;
                        exp_q.push_back(e);
                        ref_pos = 0;
                        ref_reg++;
                end
        endtask

        task automatic wait_busy_low();
                int n;
                n = 0;
                while (busy_o !== 1'b0 && n < WAIT_LIMIT) begin
                        @(negedge clk_i);
                        n++;
                end
                if (busy_o !== 1'b0) begin
                        $display("timeout: busy_o still high after %0d cycles", n);
                        proto_errs++;
                        timed_out = 1'b1;
                end
        endtask

        task automatic wait_drain();
                int n;
                n = 0;
                while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
                        @(negedge clk_i);
                        n++;
                end
                if (exp_q.size() != 0) begin
                        $display("timeout: %0d expected writes never appeared", exp_q.size());
                        proto_errs++;
                        timed_out = 1'b1;
                end
        endtask

        task automatic run_row(input int r);
                row_t               rw;
                int                 nbytes;
                int                 n_regs;
                logic [31:0]        d;
                logic               pad;
                elem_pkg::elem_in_t e;
                rw     = rows[r];
                nbytes = eew_bytes(rw.eew);
                n_regs = emul_regs(rw.emul);
                ref_pos = 0;
                ref_reg = 0;
                for (int i = 0; i < rw.n_elem; i++) begin
                        take_bits(32, d);
                        e.ctrl.id        = rw.id;
                        e.ctrl.eew       = rw.eew;
                        e.ctrl.emul      = rw.emul;
                        e.ctrl.vaddr     = rw.vaddr;
                        e.first          = (i == 0);
                        e.last           = (i == rw.n_elem - 1);
                        e.requires_flush = rw.flush;
                        e.data           = d;
                        e.mask           = rw.mask_pat[i % 32];
                        @(posedge clk_i);
                        elem_valid_i <= 1'b1;
                        elem_i       <= e;
                        // Sampled on the next edge, written one edge after that.
                        model_element(r, nbytes, n_regs, d, e.mask, e.last, cyc + 2);
                end
                if (rw.flush) begin
                        pad = (ref_reg < n_regs);
                        while (ref_reg < n_regs) begin
                                model_element(r, nbytes, n_regs, '0, 1'b0, 1'b1, -1);
                        end
                        @(posedge clk_i);
                        elem_valid_i <= 1'b0;
                        @(negedge clk_i);
                        check_flag("busy_o", busy_o, pad);
                        wait_busy_low();
                end
        endtask

        // Write port monitor.
        always @(negedge clk_i) begin
                exp_t e;
                if (async_rst_ni === 1'b1) begin
                        if (wr_valid_o === 1'b1 && exp_q.size() == 0) begin
                                $display("unexpected write to vaddr 0x%h", wr_ctrl_o.vaddr);
                                proto_errs++;
                        end else if (wr_valid_o === 1'b1) begin
                                e = exp_q.pop_front();
                                check_ctrl(wr_ctrl_o, e.ctrl);
                                check_data(wr_data_o, e.data);
                                check_ben(wr_ben_o, e.ben);
                                check_flag("done_o", done_o, e.ctrl.instr_done);
                                if (e.ctrl.instr_done) begin
                                        check_flag("busy_o", busy_o, 1'b0);
                                end
                                if (e.due >= 0 && cyc != e.due) begin
                                        $display("write to vaddr 0x%h came in cycle %0d, not %0d",
                                                 wr_ctrl_o.vaddr, cyc, e.due);
                                        proto_errs++;
                                end
                                seen[e.row]++;
                        end else begin
                                check_flag("done_o", done_o, 1'b0);
                        end
                end
        end

        initial begin
                clk_i        = 1'b0;
                async_rst_ni = 1'b0;
                elem_valid_i = 1'b0;
                elem_i       = '0;
                cyc          = 0;
                n_checks     = 0;
                value_errs   = 0;
                proto_errs   = 0;
                timed_out    = 1'b0;
                // id, eew, emul, vaddr, flush, elements, mask pattern, writes
                rows[0] = '{3'd1, elem_pkg::EEW_8,  elem_pkg::EMUL_1, 5'd0,  1'b0, 16, 32'hffff_ffff, 1};
                rows[1] = '{3'd2, elem_pkg::EEW_16, elem_pkg::EMUL_1, 5'd1,  1'b0, 8,  32'hffff_ffff, 1};
                rows[2] = '{3'd3, elem_pkg::EEW_32, elem_pkg::EMUL_1, 5'd2,  1'b0, 4,  32'hffff_ffff, 1};
                rows[3] = '{3'd4, elem_pkg::EEW_8,  elem_pkg::EMUL_1, 5'd3,  1'b0, 16, 32'h0000_a5c3, 1};
                rows[4] = '{3'd5, elem_pkg::EEW_32, elem_pkg::EMUL_4, 5'd8,  1'b0, 16, 32'hffff_ffff, 4};
                rows[5] = '{3'd6, elem_pkg::EEW_16, elem_pkg::EMUL_2, 5'd4,  1'b1, 5,  32'hffff_ffff, 2};
                rows[6] = '{3'd7, elem_pkg::EEW_16, elem_pkg::EMUL_2, 5'd6,  1'b1, 16, 32'h0000_f0f0, 2};
                rows[7] = '{3'd0, elem_pkg::EEW_8,  elem_pkg::EMUL_8, 5'd16, 1'b1, 20, 32'hdead_beef, 8};
                rows[8] = '{3'd1, elem_pkg::EEW_32, elem_pkg::EMUL_2, 5'd24, 1'b0, 8,  32'h0000_005a, 2};
                for (int r = 0; r < N_ROWS; r++) begin
                        seen[r] = 0;
                end
                repeat (3) @(posedge clk_i);
                async_rst_ni <= 1'b1;
                @(negedge clk_i);
                check_flag("wr_valid_o", wr_valid_o, 1'b0);
                check_flag("done_o", done_o, 1'b0);
                check_flag("busy_o", busy_o, 1'b0);
                for (int r = 0; r < N_ROWS; r++) begin
                        if (!timed_out) begin
                                run_row(r);
                        end
                end
                @(posedge clk_i);
                elem_valid_i <= 1'b0;
                wait_drain();
                repeat (4) @(negedge clk_i);
                for (int r = 0; r < N_ROWS; r++) begin
                        if (seen[r] != rows[r].n_writes) begin
                                $display("instruction %0d gave %0d writes instead of %0d",
                                         r, seen[r], rows[r].n_writes);
                                proto_errs++;
                        end
                end
                $display("checks: %0d, value errors: %0d, other errors: %0d",
                         n_checks, value_errs, proto_errs);
                if (value_errs == 0 && proto_errs == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule

// File: project.f
verilog/elem_pkg.sv
verilog/elem_flush_fsm.sv
verilog/elem_byte_counter.sv
verilog/elem_vreg_packer.sv
verilog/elem_result_collector.sv
test/elem_result_collector_assert.sv
test/tb_elem_result_collector.sv

// File: Makefile
TOP := tb_elem_result_collector

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
